/* hdl/soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// SRAM window, a word-addressed array starting at the base.
`define SRAM_BASE        32'h8000_0000
`define SRAM_DEPTH_WORDS 256
`define SRAM_INDEX_BITS  8

// The two mtime words of the CLINT.
`define MTIME_LO_ADDR    32'h0200_0048
`define MTIME_HI_ADDR    32'h0200_004c

`define RESP_OKAY        2'b00
`define RESP_DECERR      2'b11 // Returned for unmapped addresses.

`endif

/* hdl/soc_pkg.sv */
`default_nettype none

package soc_pkg;

  typedef logic [31:0] addr_t; // Byte address.
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t; // One strobe per byte lane.
  typedef logic [1:0]  resp_t;

  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_t;

  // Which master owns the bus for the current transaction.
  typedef enum logic {
    GRANT_FETCH,
    GRANT_LSU
  } grant_t;

  typedef enum logic [1:0] {
    TGT_SRAM,
    TGT_TIMER,
    TGT_ERROR
  } target_t;

endpackage

`default_nettype wire

/* hdl/clint_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module clint_timer (
  input  wire                 clock,
  input  wire                 reset,

  input  wire soc_pkg::addr_t araddr,
  input  wire                 arvalid,
  output logic                arready,

  output soc_pkg::data_t      rdata,
  output soc_pkg::resp_t      rresp,
  output logic                rvalid,
  input  wire                 rready
);

  logic [63:0] mtime;

  // A new address is taken only once the previous response has left.
  assign arready = !rvalid;
  assign rresp   = `RESP_OKAY;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // Only the two mtime words are routed here, so bit 2 picks the half.
  always_ff @(posedge clock) begin
    if (arvalid && arready) begin
      rdata <= araddr[2] ? mtime[63:32] : mtime[31:0];
    end
  end

  // The sampled value must not move while the master stalls.
  assert property (@(posedge clock) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("clint_timer: read data changed under back-pressure");

endmodule

`default_nettype wire

/* hdl/bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module bus_arbiter (
  input  wire                 clock,
  input  wire                 reset,

  input  wire soc_pkg::addr_t f_araddr,
  input  wire                 f_arvalid,
  output logic                f_arready,
  output soc_pkg::data_t      f_rdata,
  output soc_pkg::resp_t      f_rresp,
  output logic                f_rvalid,
  input  wire                 f_rready,

  input  wire soc_pkg::addr_t l_araddr,
  input  wire                 l_arvalid,
  output logic                l_arready,
  output soc_pkg::data_t      l_rdata,
  output soc_pkg::resp_t      l_rresp,
  output logic                l_rvalid,
  input  wire                 l_rready,
  input  wire soc_pkg::addr_t l_awaddr,
  input  wire                 l_awvalid,
  output logic                l_awready,
  input  wire soc_pkg::data_t l_wdata,
  input  wire soc_pkg::strb_t l_wstrb,
  input  wire                 l_wvalid,
  output logic                l_wready,
  output soc_pkg::resp_t      l_bresp,
  output logic                l_bvalid,
  input  wire                 l_bready,

  output soc_pkg::addr_t      s_araddr,
  output logic                s_arvalid,
  input  wire                 s_arready,
  input  wire soc_pkg::data_t s_rdata,
  input  wire soc_pkg::resp_t s_rresp,
  input  wire                 s_rvalid,
  output logic                s_rready,
  output soc_pkg::addr_t      s_awaddr,
  output logic                s_awvalid,
  input  wire                 s_awready,
  output soc_pkg::data_t      s_wdata,
  output soc_pkg::strb_t      s_wstrb,
  output logic                s_wvalid,
  input  wire                 s_wready,
  input  wire soc_pkg::resp_t s_bresp,
  input  wire                 s_bvalid,
  output logic                s_bready
);

  localparam soc_pkg::addr_t sram_bytes = `SRAM_DEPTH_WORDS * 4;

  soc_pkg::arb_state_t state;
  soc_pkg::grant_t     grant;
  soc_pkg::target_t    target;
  logic                write_op;
  logic                addr_taken; // Address phase of the granted transfer is over.
  logic                err_rvalid;
  logic                err_bvalid;

  logic                req_any;
  logic                req_write;
  soc_pkg::addr_t      req_addr;

  soc_pkg::addr_t      m_araddr;
  logic                m_arvalid;
  logic                m_rready;
  logic                rd_active;
  logic                wr_active;
  logic                fwd_ar;
  logic                fwd_aw;

  logic                sel_arready;
  soc_pkg::data_t      sel_rdata;
  soc_pkg::resp_t      sel_rresp;
  logic                sel_rvalid;
  logic                sel_awready;
  logic                sel_wready;
  soc_pkg::resp_t      sel_bresp;
  logic                sel_bvalid;

  logic                port_arready;
  logic                port_rvalid;
  logic                ar_hs;
  logic                aw_hs;
  logic                rd_done;
  logic                wr_done;
  logic                xact_done;

  soc_pkg::addr_t      t_araddr;
  logic                t_arvalid;
  logic                t_arready;
  soc_pkg::data_t      t_rdata;
  soc_pkg::resp_t      t_rresp;
  logic                t_rvalid;
  logic                t_rready;

  // mtime is read-only, so a write to it falls through to the error responder.
  function automatic soc_pkg::target_t decode_target(input soc_pkg::addr_t addr,
                                                     input logic is_write);
    if (!is_write && (addr == `MTIME_LO_ADDR || addr == `MTIME_HI_ADDR)) begin
      return soc_pkg::TGT_TIMER;
    end
    if (addr >= `SRAM_BASE && (addr - `SRAM_BASE) < sram_bytes) begin
      return soc_pkg::TGT_SRAM;
    end
    return soc_pkg::TGT_ERROR;
  endfunction

  // Fixed priority: fetch read, then load/store read, then load/store write.
  assign req_any   = f_arvalid || l_arvalid || (l_awvalid && l_wvalid);
  assign req_write = !f_arvalid && !l_arvalid;

  always_comb begin
    if (f_arvalid) begin
      req_addr = f_araddr;
    end else if (l_arvalid) begin
      req_addr = l_araddr;
    end else begin
      req_addr = l_awaddr;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= soc_pkg::ARB_IDLE;
      grant      <= soc_pkg::GRANT_FETCH;
      target     <= soc_pkg::TGT_ERROR;
      write_op   <= 1'b0;
      addr_taken <= 1'b0;
    end else begin
      case (state)
        soc_pkg::ARB_IDLE: begin
          if (req_any) begin
            state      <= soc_pkg::ARB_BUSY;
            grant      <= f_arvalid ? soc_pkg::GRANT_FETCH : soc_pkg::GRANT_LSU;
            target     <= decode_target(req_addr, req_write);
            write_op   <= req_write;
            addr_taken <= 1'b0;
          end
        end
        soc_pkg::ARB_BUSY: begin
          if (ar_hs || aw_hs) begin
            addr_taken <= 1'b1;
          end
          if (xact_done) begin
            state <= soc_pkg::ARB_IDLE;
          end
        end
        default: state <= soc_pkg::ARB_IDLE;
      endcase
    end
  end

  // Error responder answers one cycle after it takes the address.
  always_ff @(posedge clock) begin
    if (reset) begin
      err_rvalid <= 1'b0;
      err_bvalid <= 1'b0;
    end else begin
      if (ar_hs && target == soc_pkg::TGT_ERROR) begin
        err_rvalid <= 1'b1;
      end else if (rd_done) begin
        err_rvalid <= 1'b0;
      end
      if (aw_hs && target == soc_pkg::TGT_ERROR) begin
        err_bvalid <= 1'b1;
      end else if (wr_done) begin
        err_bvalid <= 1'b0;
      end
    end
  end

  always_comb begin
    if (grant == soc_pkg::GRANT_LSU) begin
      m_araddr  = l_araddr;
      m_arvalid = l_arvalid;
      m_rready  = l_rready;
    end else begin
      m_araddr  = f_araddr;
      m_arvalid = f_arvalid;
      m_rready  = f_rready;
    end
  end

  assign rd_active = (state == soc_pkg::ARB_BUSY) && !write_op;
  assign wr_active = (state == soc_pkg::ARB_BUSY) && write_op;
  assign fwd_ar    = rd_active && !addr_taken && m_arvalid;
  assign fwd_aw    = wr_active && !addr_taken;

  assign s_araddr  = m_araddr;
  assign s_arvalid = fwd_ar && target == soc_pkg::TGT_SRAM;
  assign s_rready  = rd_active && target == soc_pkg::TGT_SRAM && m_rready;
  assign s_awaddr  = l_awaddr;
  assign s_awvalid = fwd_aw && target == soc_pkg::TGT_SRAM && l_awvalid;
  assign s_wdata   = l_wdata;
  assign s_wstrb   = l_wstrb;
  assign s_wvalid  = fwd_aw && target == soc_pkg::TGT_SRAM && l_wvalid;
  assign s_bready  = wr_active && target == soc_pkg::TGT_SRAM && l_bready;

  assign t_araddr  = m_araddr;
  assign t_arvalid = fwd_ar && target == soc_pkg::TGT_TIMER;
  assign t_rready  = rd_active && target == soc_pkg::TGT_TIMER && m_rready;

  always_comb begin
    sel_arready = 1'b0;
    sel_rdata   = '0;
    sel_rresp   = `RESP_DECERR;
    sel_rvalid  = 1'b0;
    sel_awready = 1'b0;
    sel_wready  = 1'b0;
    sel_bresp   = `RESP_DECERR;
    sel_bvalid  = 1'b0;
    case (target)
      soc_pkg::TGT_SRAM: begin
        sel_arready = s_arready;
        sel_rdata   = s_rdata;
        sel_rresp   = s_rresp;
        sel_rvalid  = s_rvalid;
        sel_awready = s_awready;
        sel_wready  = s_wready;
        sel_bresp   = s_bresp;
        sel_bvalid  = s_bvalid;
      end
      soc_pkg::TGT_TIMER: begin
        sel_arready = t_arready;
        sel_rdata   = t_rdata;
        sel_rresp   = t_rresp;
        sel_rvalid  = t_rvalid;
      end
      default: begin
        sel_arready = 1'b1; // Unmapped reads are taken at once.
        sel_rvalid  = err_rvalid;
        sel_awready = l_awvalid && l_wvalid;
        sel_wready  = l_awvalid && l_wvalid;
        sel_bvalid  = err_bvalid;
      end
    endcase
  end

  assign port_arready = rd_active && !addr_taken && sel_arready;
  assign port_rvalid  = rd_active && sel_rvalid;

  assign ar_hs     = port_arready && m_arvalid;
  assign aw_hs     = fwd_aw && l_awvalid && l_wvalid && sel_awready && sel_wready;
  assign rd_done   = port_rvalid && m_rready;
  assign wr_done   = wr_active && sel_bvalid && l_bready;
  assign xact_done = rd_done || wr_done;

  assign f_arready = grant == soc_pkg::GRANT_FETCH && port_arready;
  assign f_rvalid  = grant == soc_pkg::GRANT_FETCH && port_rvalid;
  assign f_rdata   = grant == soc_pkg::GRANT_FETCH ? sel_rdata : '0;
  assign f_rresp   = grant == soc_pkg::GRANT_FETCH ? sel_rresp : `RESP_OKAY;

  assign l_arready = grant == soc_pkg::GRANT_LSU && port_arready;
  assign l_rvalid  = grant == soc_pkg::GRANT_LSU && port_rvalid;
  assign l_rdata   = grant == soc_pkg::GRANT_LSU ? sel_rdata : '0;
  assign l_rresp   = grant == soc_pkg::GRANT_LSU ? sel_rresp : `RESP_OKAY;
  assign l_awready = fwd_aw && sel_awready;
  assign l_wready  = fwd_aw && sel_wready;
  assign l_bvalid  = wr_active && sel_bvalid;
  assign l_bresp   = sel_bresp;

  clint_timer u_timer (
    .clock  (clock),
    .reset  (reset),
    .araddr (t_araddr),
    .arvalid(t_arvalid),
    .arready(t_arready),
    .rdata  (t_rdata),
    .rresp  (t_rresp),
    .rvalid (t_rvalid),
    .rready (t_rready)
  );

  // The owner of the bus is fixed until its response has been taken.
  assert property (@(posedge clock) disable iff (reset)
    state == soc_pkg::ARB_BUSY && !xact_done |=>
      state == soc_pkg::ARB_BUSY && $stable(grant) && $stable(target))
    else $error("bus_arbiter: grant moved during a transaction");

  assert property (@(posedge clock) disable iff (reset)
    !(f_rvalid && (l_rvalid || l_bvalid)))
    else $error("bus_arbiter: both ports see a response");

endmodule

`default_nettype wire

/* hdl/sram_slave.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module sram_slave (
  input  wire                 clock,
  input  wire                 reset,

  input  wire soc_pkg::addr_t araddr,
  input  wire                 arvalid,
  output logic                arready,
  output soc_pkg::data_t      rdata,
  output soc_pkg::resp_t      rresp,
  output logic                rvalid,
  input  wire                 rready,

  input  wire soc_pkg::addr_t awaddr,
  input  wire                 awvalid,
  output logic                awready,
  input  wire soc_pkg::data_t wdata,
  input  wire soc_pkg::strb_t wstrb,
  input  wire                 wvalid,
  output logic                wready,
  output soc_pkg::resp_t      bresp,
  output logic                bvalid,
  input  wire                 bready
);

  soc_pkg::data_t              mem [`SRAM_DEPTH_WORDS];
  logic [`SRAM_INDEX_BITS-1:0] rd_index;
  logic [`SRAM_INDEX_BITS-1:0] wr_index;
  logic                        rd_accept;
  logic                        wr_accept;

  // Word index sits just above the byte offset.
  assign rd_index = araddr[`SRAM_INDEX_BITS+1:2];
  assign wr_index = awaddr[`SRAM_INDEX_BITS+1:2];

  assign arready   = !rvalid;
  assign rd_accept = arvalid && arready;

  // Address and data of a write are always taken together.
  assign wr_accept = awvalid && wvalid && !bvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;

  assign rresp = `RESP_OKAY;
  assign bresp = `RESP_OKAY;

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_accept) begin
      rdata <= mem[rd_index];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      bvalid <= 1'b0;
    end else if (wr_accept) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_accept) begin
      for (int i = 0; i < 4; i++) begin
        if (wstrb[i]) begin
          mem[wr_index][8*i +: 8] <= wdata[8*i +: 8]; // Unstrobed lanes keep old bytes.
        end
      end
    end
  end

  // The arbiter serves one transaction at a time, so a read never meets a write here.
  assert property (@(posedge clock) disable iff (reset)
    !(arvalid && (awvalid || wvalid)))
    else $error("sram_slave: read and write requested together");

endmodule

`default_nettype wire

/* hdl/mem_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem (
  input  wire                 clock,
  input  wire                 reset,

  input  wire soc_pkg::addr_t f_araddr,
  input  wire                 f_arvalid,
  output logic                f_arready,
  output soc_pkg::data_t      f_rdata,
  output soc_pkg::resp_t      f_rresp,
  output logic                f_rvalid,
  input  wire                 f_rready,

  input  wire soc_pkg::addr_t l_araddr,
  input  wire                 l_arvalid,
  output logic                l_arready,
  output soc_pkg::data_t      l_rdata,
  output soc_pkg::resp_t      l_rresp,
  output logic                l_rvalid,
  input  wire                 l_rready,
  input  wire soc_pkg::addr_t l_awaddr,
  input  wire                 l_awvalid,
  output logic                l_awready,
  input  wire soc_pkg::data_t l_wdata,
  input  wire soc_pkg::strb_t l_wstrb,
  input  wire                 l_wvalid,
  output logic                l_wready,
  output soc_pkg::resp_t      l_bresp,
  output logic                l_bvalid,
  input  wire                 l_bready
);

  // Arbiter to SRAM channels.
  soc_pkg::addr_t s_araddr;
  logic           s_arvalid;
  logic           s_arready;
  soc_pkg::data_t s_rdata;
  soc_pkg::resp_t s_rresp;
  logic           s_rvalid;
  logic           s_rready;
  soc_pkg::addr_t s_awaddr;
  logic           s_awvalid;
  logic           s_awready;
  soc_pkg::data_t s_wdata;
  soc_pkg::strb_t s_wstrb;
  logic           s_wvalid;
  logic           s_wready;
  soc_pkg::resp_t s_bresp;
  logic           s_bvalid;
  logic           s_bready;

  bus_arbiter u_arbiter (.*);

  sram_slave u_sram (
    .clock  (clock),
    .reset  (reset),
    .araddr (s_araddr),
    .arvalid(s_arvalid),
    .arready(s_arready),
    .rdata  (s_rdata),
    .rresp  (s_rresp),
    .rvalid (s_rvalid),
    .rready (s_rready),
    .awaddr (s_awaddr),
    .awvalid(s_awvalid),
    .awready(s_awready),
    .wdata  (s_wdata),
    .wstrb  (s_wstrb),
    .wvalid (s_wvalid),
    .wready (s_wready),
    .bresp  (s_bresp),
    .bvalid (s_bvalid),
    .bready (s_bready)
  );

endmodule

`default_nettype wire

/* tb/tb_mem_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_defines.svh"

module tb_mem_subsystem;

  localparam bit FETCH = 1'b0;
  localparam bit LSU   = 1'b1;

  typedef enum {OP_RD, OP_WR, OP_DUAL, OP_TIME} op_t;

  // For OP_TIME rows the stall column holds the idle gap between the two reads.
  typedef struct {
    bit             port;
    op_t            op;
    soc_pkg::addr_t addr;
    soc_pkg::data_t wdata;
    soc_pkg::strb_t strb;
    bit             random;
    soc_pkg::data_t exp_data;
    soc_pkg::resp_t exp_resp;
    int             stall;
  } row_t;

  logic clock;
  logic reset;

  soc_pkg::addr_t f_araddr;
  logic           f_arvalid;
  logic           f_arready;
  soc_pkg::data_t f_rdata;
  soc_pkg::resp_t f_rresp;
  logic           f_rvalid;
  logic           f_rready;

  soc_pkg::addr_t l_araddr;
  logic           l_arvalid;
  logic           l_arready;
  soc_pkg::data_t l_rdata;
  soc_pkg::resp_t l_rresp;
  logic           l_rvalid;
  logic           l_rready;
  soc_pkg::addr_t l_awaddr;
  logic           l_awvalid;
  logic           l_awready;
  soc_pkg::data_t l_wdata;
  soc_pkg::strb_t l_wstrb;
  logic           l_wvalid;
  logic           l_wready;
  soc_pkg::resp_t l_bresp;
  logic           l_bvalid;
  logic           l_bready;

  logic [1:0]     arready_p;
  logic [1:0]     rvalid_p;
  soc_pkg::data_t rdata_p [2];
  soc_pkg::resp_t rresp_p [2];

  row_t           rows [$];
  soc_pkg::data_t shadow [`SRAM_DEPTH_WORDS];
  logic [31:0]    lfsr_state;
  int             cycles;
  int             cycle_limit;
  int             checks;
  int             errors;

  assign arready_p  = {l_arready, f_arready};
  assign rvalid_p   = {l_rvalid, f_rvalid};
  assign rdata_p[0] = f_rdata;
  assign rdata_p[1] = l_rdata;
  assign rresp_p[0] = f_rresp;
  assign rresp_p[1] = l_rresp;

  mem_subsystem DUT (.*);

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic soc_pkg::data_t random_word();
    soc_pkg::data_t w;
    for (int i = 0; i < 32; i++) begin
      w[i]       = lfsr_state[0]; // One LFSR step per bit.
      lfsr_state = lfsr_step(lfsr_state);
    end
    return w;
  endfunction

  function automatic bit in_sram(input soc_pkg::addr_t addr);
    return addr >= `SRAM_BASE && (addr - `SRAM_BASE) < 32'(`SRAM_DEPTH_WORDS * 4);
  endfunction

  function automatic soc_pkg::data_t expected_data(input row_t r);
    return in_sram(r.addr) ? shadow[r.addr[`SRAM_INDEX_BITS+1:2]] : r.exp_data;
  endfunction

  task automatic add_row(input bit port, input op_t op, input soc_pkg::addr_t addr,
                         input soc_pkg::data_t wdata, input soc_pkg::strb_t strb,
                         input bit random, input soc_pkg::data_t exp_data,
                         input soc_pkg::resp_t exp_resp, input int stall);
    row_t r;
    r = '{port, op, addr, wdata, strb, random, exp_data, exp_resp, stall};
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row(LSU,   OP_RD,   `MTIME_HI_ADDR,       0, 0, 0, 0, `RESP_OKAY,   0);
    add_row(LSU,   OP_WR,   `SRAM_BASE + 32'h10,  32'ha5a5_5a5a, 4'hf, 0, 0, `RESP_OKAY, 0);
    add_row(LSU,   OP_WR,   `SRAM_BASE + 32'h10,  0, 4'b0101, 1, 0, `RESP_OKAY, 0);
    add_row(FETCH, OP_RD,   `SRAM_BASE + 32'h10,  0, 0, 0, 0, `RESP_OKAY,   0);
    add_row(LSU,   OP_RD,   `SRAM_BASE + 32'h10,  0, 0, 0, 0, `RESP_OKAY,   0);
    add_row(LSU,   OP_WR,   `SRAM_BASE + 32'h3fc, 32'h1234_5678, 4'hf, 0, 0, `RESP_OKAY, 0);
    add_row(FETCH, OP_DUAL, `SRAM_BASE + 32'h3fc, 0, 0, 0, 0, `RESP_OKAY,   0);
    add_row(LSU,   OP_TIME, `MTIME_LO_ADDR,       0, 0, 0, 0, `RESP_OKAY,   7);
    add_row(LSU,   OP_RD,   32'h1000_0000,        0, 0, 0, 0, `RESP_DECERR, 0);
    add_row(LSU,   OP_WR,   32'h0000_0010,        32'hdead_beef, 4'hf, 0, 0, `RESP_DECERR, 0);
    add_row(LSU,   OP_WR,   `MTIME_LO_ADDR,       32'h0bad_0bad, 4'hf, 0, 0, `RESP_DECERR, 0);
    add_row(LSU,   OP_RD,   `SRAM_BASE + 32'h10,  0, 0, 0, 0, `RESP_OKAY,   0);
    add_row(FETCH, OP_RD,   `SRAM_BASE + 32'h3fc, 0, 0, 0, 0, `RESP_OKAY,   4);
    add_row(LSU,   OP_RD,   `SRAM_BASE + 32'h10,  0, 0, 0, 0, `RESP_OKAY,   3);
    add_row(FETCH, OP_RD,   `SRAM_BASE + 32'h400, 0, 0, 0, 0, `RESP_DECERR, 0);
  endtask

  task automatic drive_ar(input bit port, input logic valid, input soc_pkg::addr_t addr);
    if (port == LSU) begin
      l_arvalid <= valid;
      l_araddr  <= addr;
    end else begin
      f_arvalid <= valid;
      f_araddr  <= addr;
    end
  endtask

  task automatic drive_rready(input bit port, input logic ready);
    if (port == LSU) l_rready <= ready;
    else f_rready <= ready;
  endtask

  task automatic read_port(input bit port, input soc_pkg::addr_t addr, input int stall,
                           output soc_pkg::data_t data, output soc_pkg::resp_t resp,
                           output int ar_cycle, output int r_cycle);
    soc_pkg::data_t held;
    @(posedge clock);
    drive_ar(port, 1'b1, addr);
    drive_rready(port, stall == 0);
    @(posedge clock);
    while (!arready_p[port]) @(posedge clock);
    ar_cycle = cycles; // Address handshake happened on this edge.
    drive_ar(port, 1'b0, addr);
    @(posedge clock);
    while (!rvalid_p[port]) @(posedge clock);
    held = rdata_p[port];
    if (stall > 0) begin
      repeat (stall) begin
        @(posedge clock);
        compare(32'(rvalid_p[port]), 32'd1, "rvalid held while rready is low");
        compare(rdata_p[port], held, "rdata stable while rready is low");
      end
      drive_rready(port, 1'b1);
      @(posedge clock);
      compare(32'(rvalid_p[port]), 32'd1, "rvalid present at the late handshake");
    end
    r_cycle = cycles;
    data    = rdata_p[port];
    resp    = rresp_p[port];
    drive_rready(port, 1'b0);
  endtask

  task automatic write_lsu(input soc_pkg::addr_t addr, input soc_pkg::data_t data,
                           input soc_pkg::strb_t strb, output soc_pkg::resp_t resp);
    @(posedge clock);
    l_awaddr  <= addr;
    l_awvalid <= 1'b1;
    l_wdata   <= data;
    l_wstrb   <= strb;
    l_wvalid  <= 1'b1;
    l_bready  <= 1'b1;
    @(posedge clock);
    while (!(l_awready && l_wready)) @(posedge clock);
    l_awvalid <= 1'b0;
    l_wvalid  <= 1'b0;
    @(posedge clock);
    while (!l_bvalid) @(posedge clock);
    resp = l_bresp;
    l_bready <= 1'b0;
  endtask

  task automatic run_row(input int n);
    row_t                        r;
    soc_pkg::data_t              data;
    soc_pkg::data_t              data2;
    soc_pkg::resp_t              resp;
    soc_pkg::resp_t              resp2;
    int                          ar1;
    int                          ar2;
    int                          rc1;
    int                          rc2;
    logic [`SRAM_INDEX_BITS-1:0] idx;
    r = rows[n];
    case (r.op)
      OP_WR: begin
        data = r.random ? random_word() : r.wdata;
        write_lsu(r.addr, data, r.strb, resp);
        compare(32'(resp), 32'(r.exp_resp), $sformatf("row %0d write response", n));
        if (in_sram(r.addr)) begin
          idx = r.addr[`SRAM_INDEX_BITS+1:2];
          for (int b = 0; b < 4; b++) begin
            if (r.strb[b]) shadow[idx][8*b +: 8] = data[8*b +: 8];
          end
        end
      end
      OP_RD: begin
        if (r.stall > 0) begin
          fork
            read_port(r.port, r.addr, r.stall, data, resp, ar1, rc1);
            begin
              repeat (3) @(posedge clock); // Raise the other port once the stalled one owns the bus.
              read_port(!r.port, r.addr, 0, data2, resp2, ar2, rc2);
            end
          join
          compare(data2, expected_data(r), $sformatf("row %0d blocked port data", n));
          compare(32'(ar2 > rc1), 32'd1, $sformatf("row %0d other port waits for stall", n));
        end else begin
          read_port(r.port, r.addr, 0, data, resp, ar1, rc1);
        end
        compare(data, expected_data(r), $sformatf("row %0d read data", n));
        compare(32'(resp), 32'(r.exp_resp), $sformatf("row %0d read response", n));
      end
      OP_DUAL: begin
        fork
          read_port(FETCH, r.addr, 0, data, resp, ar1, rc1);
          read_port(LSU, r.addr, 0, data2, resp2, ar2, rc2);
        join
        compare(data, expected_data(r), $sformatf("row %0d fetch data", n));
        compare(data2, expected_data(r), $sformatf("row %0d load/store data", n));
        compare(32'(rc1 < rc2), 32'd1, $sformatf("row %0d fetch completes first", n));
      end
      default: begin
        read_port(LSU, r.addr, 0, data, resp, ar1, rc1);
        repeat (r.stall) @(posedge clock);
        read_port(LSU, r.addr, 0, data2, resp2, ar2, rc2);
        compare(data2 - data, 32'(ar2 - ar1), $sformatf("row %0d mtime delta", n));
        compare(32'(resp2), 32'(r.exp_resp), $sformatf("row %0d mtime response", n));
      end
    endcase
  endtask

  initial begin
    clock      = 1'b0;
    reset      = 1'b1;
    f_araddr   = '0;
    f_arvalid  = 1'b0;
    f_rready   = 1'b0;
    l_araddr   = '0;
    l_arvalid  = 1'b0;
    l_rready   = 1'b0;
    l_awaddr   = '0;
    l_awvalid  = 1'b0;
    l_wdata    = '0;
    l_wstrb    = '0;
    l_wvalid   = 1'b0;
    l_bready   = 1'b0;
    lfsr_state = 32'h1767;
    cycles     = 0;
    checks     = 0;
    errors     = 0;
    build_table();
    cycle_limit = 40 * rows.size() + 100;

    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    compare(32'(f_arready), 32'd0, "fetch arready after reset");
    compare(32'(f_rvalid), 32'd0, "fetch rvalid after reset");
    compare(32'(l_arready), 32'd0, "load/store arready after reset");
    compare(32'(l_awready), 32'd0, "load/store awready after reset");
    compare(32'(l_wready), 32'd0, "load/store wready after reset");
    compare(32'(l_rvalid), 32'd0, "load/store rvalid after reset");
    compare(32'(l_bvalid), 32'd0, "load/store bvalid after reset");

    for (int n = 0; n < rows.size(); n++) begin
      run_row(n);
    end

    $display("checks run: %0d, mismatches: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
hdl/soc_pkg.sv
hdl/clint_timer.sv
hdl/bus_arbiter.sv
hdl/sram_slave.sv
hdl/mem_subsystem.sv
tb/tb_mem_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_mem_subsystem
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)

.PHONY: all build run clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator output goes to the log, and the result is read from it.
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
